// ==== ooo_alu_core.f ====
+incdir+testbench
hdl/rs_pkg.sv
hdl/exec_timer.sv
hdl/alu_unit.sv
hdl/rs_alu.sv
hdl/alu_issue_ctrl.sv
hdl/ooo_alu_core.sv
testbench/tb_ooo_alu_core.sv

// ==== Makefile ====
TB_TOP = tb_ooo_alu_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f ooo_alu_core.f --top-module ooo_alu_core

sim:
	verilator --binary --timing -f ooo_alu_core.f --top-module $(TB_TOP)
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== testbench/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// expected result of one ALU operation.
function automatic logic [rs_pkg::WORD_W-1:0] ref_result(
    input rs_pkg::alu_op_t           op,
    input logic [rs_pkg::WORD_W-1:0] x,
    input logic [rs_pkg::WORD_W-1:0] y
);
    logic [2*rs_pkg::WORD_W-1:0] product;
    logic [rs_pkg::WORD_W-1:0]   left;
    logic [rs_pkg::WORD_W-1:0]   right;
    int                          amount;

    amount = int'(y[4:0]);
    product = {32'b0, x} * {32'b0, y};
    left = x;
    right = x;

    // shift one place at a time, amount times.
    for (int i = 0; i < rs_pkg::WORD_W; i++) begin
        if (i < amount) begin
            left = {left[rs_pkg::WORD_W-2:0], 1'b0};
            right = {1'b0, right[rs_pkg::WORD_W-1:1]};
        end
    end

    case (op)
        rs_pkg::op_add: ref_result = x + y;
        rs_pkg::op_sub: ref_result = x + ~y + 32'd1; // two's complement negate.
        rs_pkg::op_and: ref_result = x & y;
        rs_pkg::op_or:  ref_result = x | y;
        rs_pkg::op_xor: ref_result = x ^ y;
        rs_pkg::op_sll: ref_result = left;
        rs_pkg::op_srl: ref_result = right;
        rs_pkg::op_mul: ref_result = product[rs_pkg::WORD_W-1:0];
        default:        ref_result = '0;
    endcase
endfunction

`endif

// ==== testbench/tb_ooo_alu_core.sv ====
`timescale 1ns/1ns

module tb_ooo_alu_core;

    localparam int N_RANDOM = 60;
    localparam int N_INSTR = N_RANDOM + 24; // directed instructions and loads included.
    localparam int LIMIT_CYCLES = N_INSTR * (rs_pkg::MUL_CYCLES + 20);

    logic              clk = 1'b0;
    logic              rst;
    logic              dispatch_en;
    rs_pkg::dispatch_t dispatch;
    rs_pkg::cdb_t      ls_cdb;
    logic              rs_full;
    rs_pkg::cdb_t      cdb;

    integer seed = 8;
    int     value_errors = 0;
    int     other_errors = 0;
    int     sent = 0;
    int     seen = 0;
    bit     full_seen = 1'b0;

    // scoreboard indexed by tag; tag 0 is never handed out.
    bit                        in_flight [16];
    bit                        is_load [16];
    bit                        load_wait [16]; // reserved load not yet on the bus.
    rs_pkg::alu_op_t           sb_op [16];
    logic [rs_pkg::TAG_W-1:0]  sb_tag_x [16];
    logic [rs_pkg::TAG_W-1:0]  sb_tag_y [16];
    logic [rs_pkg::WORD_W-1:0] sb_x [16];
    logic [rs_pkg::WORD_W-1:0] sb_y [16];

    `include "tb_ref.svh"

    ooo_alu_core dut_i (
        .clk         (clk),
        .rst         (rst),
        .dispatch_en (dispatch_en),
        .dispatch    (dispatch),
        .ls_cdb      (ls_cdb),
        .rs_full     (rs_full),
        .cdb         (cdb)
    );

    always #5 clk = ~clk;

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_fault(input string what);
        other_errors++;
        $display("at %0t ns: %s", $time, what);
    endtask

    // mode 0 finds a free tag, 1 a tag in flight, 2 a load still to be driven.
    function automatic logic [rs_pkg::TAG_W-1:0] pick_tag(input int mode);
        int                       start;
        logic [rs_pkg::TAG_W-1:0] t;
        bit                       hit;
        start = {$random(seed)} % 15;
        pick_tag = rs_pkg::TAG_UNLOCKED;
        for (int k = 0; k < 15; k++) begin
            t = 4'(1 + (start + k) % 15);
            hit = (mode == 0) ? !in_flight[t] : (mode == 1) ? in_flight[t] : load_wait[t];
            if (hit && pick_tag == rs_pkg::TAG_UNLOCKED) begin
                pick_tag = t;
            end
        end
    endfunction

    function automatic bit any_in_flight();
        any_in_flight = 1'b0;
        for (int k = 1; k < 16; k++) begin
            if (in_flight[4'(k)]) begin
                any_in_flight = 1'b1;
            end
        end
    endfunction

    // checks one broadcast and hands its value to waiting consumers.
    task automatic retire(input logic [rs_pkg::TAG_W-1:0] t, input logic [31:0] d);
        logic [rs_pkg::WORD_W-1:0] exp;
        logic [rs_pkg::TAG_W-1:0]  c;
        if (t == rs_pkg::TAG_UNLOCKED || !in_flight[t]) begin
            report_fault($sformatf("broadcast of tag %0d, which is not in flight", t));
        end else begin
            if (is_load[t]) begin
                exp = sb_x[t];
            end else begin
                if (sb_tag_x[t] != rs_pkg::TAG_UNLOCKED || sb_tag_y[t] != rs_pkg::TAG_UNLOCKED) begin
                    report_fault($sformatf("tag %0d broadcast before its sources", t));
                end
                exp = ref_result(sb_op[t], sb_x[t], sb_y[t]);
            end
            compare($sformatf("cdb.data of tag %0d", t), 64'(d), 64'(exp));
            in_flight[t] = 1'b0;
            is_load[t] = 1'b0;
            seen++;
            for (int k = 1; k < 16; k++) begin
                c = 4'(k);
                if (in_flight[c] && !is_load[c] && sb_tag_x[c] == t) begin
                    sb_x[c] = d;
                    sb_tag_x[c] = rs_pkg::TAG_UNLOCKED;
                end
                if (in_flight[c] && !is_load[c] && sb_tag_y[c] == t) begin
                    sb_y[c] = d;
                    sb_tag_y[c] = rs_pkg::TAG_UNLOCKED;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (rs_full) begin
                full_seen = 1'b1;
            end
            if (ls_cdb.valid) begin
                compare("cdb", 64'(cdb), 64'(ls_cdb)); // load/store owns the bus.
            end
            if (cdb.valid) begin
                retire(cdb.tag, cdb.data);
            end
        end
    end

    task automatic next_cycle();
        @(negedge clk);
        dispatch_en = 1'b0;
        ls_cdb = '0;
    endtask

    task automatic wait_room();
        next_cycle();
        while (rs_full) begin
            next_cycle();
        end
    endtask

    task automatic reserve_load(output logic [rs_pkg::TAG_W-1:0] t);
        t = pick_tag(0);
        in_flight[t] = 1'b1;
        is_load[t] = 1'b1;
        load_wait[t] = 1'b1;
        sb_tag_x[t] = rs_pkg::TAG_UNLOCKED;
        sb_tag_y[t] = rs_pkg::TAG_UNLOCKED;
        sent++;
    endtask

    task automatic drive_load(input logic [rs_pkg::TAG_W-1:0] t);
        load_wait[t] = 1'b0;
        sb_x[t] = $random(seed);
        ls_cdb.valid = 1'b1;
        ls_cdb.tag = t;
        ls_cdb.data = sb_x[t];
    endtask

    task automatic send(
        input  rs_pkg::alu_op_t           op,
        input  logic [rs_pkg::TAG_W-1:0]  tx,
        input  logic [rs_pkg::WORD_W-1:0] dx,
        input  logic [rs_pkg::TAG_W-1:0]  ty,
        input  logic [rs_pkg::WORD_W-1:0] dy,
        output logic [rs_pkg::TAG_W-1:0]  w
    );
        w = pick_tag(0);
        in_flight[w] = 1'b1;
        sb_op[w] = op;
        sb_tag_x[w] = tx;
        sb_tag_y[w] = ty;
        sb_x[w] = dx; // a tag source overwrites this when it broadcasts.
        sb_y[w] = dy;
        sent++;
        dispatch.op = op;
        dispatch.tag_x = tx;
        dispatch.tag_y = ty;
        dispatch.tag_w = w;
        dispatch.data_x = dx;
        dispatch.data_y = dy;
        dispatch_en = 1'b1;
    endtask

    task automatic random_source(output logic [rs_pkg::TAG_W-1:0] t, output logic [31:0] d);
        d = $random(seed);
        t = ({$random(seed)} % 4 >= 2) ? pick_tag(1) : rs_pkg::TAG_UNLOCKED;
    endtask

    task automatic drain();
        logic [rs_pkg::TAG_W-1:0] t;
        while (any_in_flight()) begin
            next_cycle();
            t = pick_tag(2);
            if (t != rs_pkg::TAG_UNLOCKED) begin
                drive_load(t);
            end
        end
    endtask

    initial begin
        logic [rs_pkg::TAG_W-1:0] t;
        logic [rs_pkg::TAG_W-1:0] w;
        logic [rs_pkg::TAG_W-1:0] tx;
        logic [rs_pkg::TAG_W-1:0] ty;
        logic [rs_pkg::TAG_W-1:0] lt [4];
        logic [31:0]              dx;
        logic [31:0]              dy;
        int                       n;

        rst = 1'b1;
        dispatch_en = 1'b0;
        dispatch = '0;
        ls_cdb = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        compare("cdb.valid", 64'(cdb.valid), 64'(0));
        compare("rs_full", 64'(rs_full), 64'(0));

        for (int k = 0; k < 8; k++) begin
            wait_room();
            send(rs_pkg::alu_op_t'(3'(k)), 4'd0, $random(seed), 4'd0, $random(seed), w);
        end
        drain();

        // both entries wait on one load, so the station fills.
        reserve_load(t);
        wait_room();
        send(rs_pkg::op_add, t, $random(seed), 4'd0, $random(seed), w);
        next_cycle();
        send(rs_pkg::op_mul, 4'd0, $random(seed), t, $random(seed), w);
        next_cycle();
        compare("rs_full", 64'(rs_full), 64'(1));
        drive_load(t);

        // the consumer dispatches in the cycle its load broadcasts.
        reserve_load(t);
        wait_room();
        drive_load(t);
        ty = in_flight[w] ? w : 4'd0;
        send(rs_pkg::op_xor, t, $random(seed), ty, $random(seed), w);
        drain();

        for (int k = 0; k < 4; k++) begin
            reserve_load(lt[k]);
        end
        wait_room();
        send(rs_pkg::op_sub, 4'd0, $random(seed), 4'd0, $random(seed), w);
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            drive_load(lt[k]); // holds the bus across the ALU broadcast.
        end
        drain();

        n = 0;
        while (n < N_RANDOM) begin
            next_cycle();
            t = pick_tag(2);
            if (t != rs_pkg::TAG_UNLOCKED && {$random(seed)} % 3 == 0) begin
                drive_load(t);
            end
            if ({$random(seed)} % 4 == 0 && pick_tag(2) == rs_pkg::TAG_UNLOCKED) begin
                reserve_load(t);
            end
            if (!rs_full && {$random(seed)} % 2 == 0) begin
                random_source(tx, dx);
                random_source(ty, dy);
                send(rs_pkg::alu_op_t'(3'({$random(seed)} % 8)), tx, dx, ty, dy, w);
                n++;
            end
        end
        drain();
        next_cycle();

        compare("broadcast count", 64'(seen), 64'(sent));
        if (!full_seen) begin
            report_fault("rs_full never went high");
        end
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the run did not end within %0d cycles", LIMIT_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== hdl/ooo_alu_core.sv ====
`timescale 1ns/1ns

module ooo_alu_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch_en,
    input  rs_pkg::dispatch_t dispatch,
    input  rs_pkg::cdb_t      ls_cdb,
    output logic              rs_full,
    output rs_pkg::cdb_t      cdb
);

    logic                      issue_valid;
    rs_pkg::rs_entry_t         issue_entry;
    logic                      issue_take;
    logic                      exec_load;
    logic                      timer_start;
    logic                      timer_done;
    logic [rs_pkg::WORD_W-1:0] alu_result;

    rs_alu rs_alu_i (
        .clk         (clk),
        .rst         (rst),
        .dispatch_en (dispatch_en),
        .dispatch    (dispatch),
        .cdb         (cdb), // the station snoops its own merged bus.
        .issue_take  (issue_take),
        .rs_full     (rs_full),
        .issue_valid (issue_valid),
        .issue_idx   (), // used inside the station to free the taken entry.
        .issue_entry (issue_entry)
    );

    alu_issue_ctrl alu_issue_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry),
        .alu_result  (alu_result),
        .timer_done  (timer_done),
        .ls_cdb      (ls_cdb),
        .issue_take  (issue_take),
        .exec_load   (exec_load),
        .timer_start (timer_start),
        .cdb         (cdb)
    );

    exec_timer exec_timer_i (
        .clk         (clk),
        .rst         (rst),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    alu_unit alu_unit_i (
        .clk         (clk),
        .rst         (rst),
        .exec_load   (exec_load),
        .issue_entry (issue_entry),
        .alu_result  (alu_result)
    );

endmodule

// ==== hdl/alu_issue_ctrl.sv ====
`timescale 1ns/1ns

module alu_issue_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  rs_pkg::rs_entry_t         issue_entry,
    input  logic [rs_pkg::WORD_W-1:0] alu_result,
    input  logic                      timer_done,
    input  rs_pkg::cdb_t              ls_cdb,
    output logic                      issue_take,
    output logic                      exec_load,
    output logic                      timer_start,
    output rs_pkg::cdb_t              cdb
);

    rs_pkg::issue_state_t state;
    rs_pkg::issue_state_t state_next;

    logic [rs_pkg::TAG_W-1:0] tag_q; // destination of the operation in flight.
    logic                     mul_q;
    logic                     exec_done;
    logic                     alu_grant;

    assign issue_take = (state == rs_pkg::st_idle) && issue_valid;
    assign exec_load = issue_take;
    assign timer_start = issue_take && (issue_entry.op == rs_pkg::op_mul);

    assign exec_done = !mul_q || timer_done;
    assign alu_grant = (state == rs_pkg::st_bcast) && !ls_cdb.valid;

    always_comb begin
        state_next = state;
        case (state)
            rs_pkg::st_idle: begin
                if (issue_valid) begin
                    state_next = rs_pkg::st_exec;
                end
            end
            rs_pkg::st_exec: begin
                if (exec_done) begin
                    state_next = rs_pkg::st_bcast;
                end
            end
            rs_pkg::st_bcast: begin
                if (alu_grant) begin
                    state_next = rs_pkg::st_idle;
                end
            end
            default: begin
                state_next = rs_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rs_pkg::st_idle;
            mul_q <= 1'b0;
        end else begin
            state <= state_next;
            if (issue_take) begin
                mul_q <= (issue_entry.op == rs_pkg::op_mul);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_take) begin
            tag_q <= issue_entry.tag_w;
        end
    end

    // load/store always wins the bus; the ALU result waits in st_bcast.
    always_comb begin
        if (ls_cdb.valid) begin
            cdb = ls_cdb;
        end else begin
            cdb.valid = alu_grant;
            cdb.tag = tag_q;
            cdb.data = alu_result;
        end
    end

endmodule

// ==== hdl/rs_alu.sv ====
`timescale 1ns/1ns

module rs_alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch_en,
    input  rs_pkg::dispatch_t dispatch,
    input  rs_pkg::cdb_t      cdb,
    input  logic              issue_take,
    output logic              rs_full,
    output logic              issue_valid,
    output logic              issue_idx,
    output rs_pkg::rs_entry_t issue_entry
);

    rs_pkg::rs_entry_t ent [rs_pkg::RS_DEPTH];

    logic [rs_pkg::RS_DEPTH-1:0] busy_vec;
    logic [rs_pkg::RS_DEPTH-1:0] ready_vec;
    logic                        free_idx;
    logic                        accept;

    // a locked tag matches a live broadcast carrying that tag.
    function automatic logic cdb_hit(
        input logic [rs_pkg::TAG_W-1:0] tag,
        input rs_pkg::cdb_t             bus
    );
        cdb_hit = bus.valid && (tag != rs_pkg::TAG_UNLOCKED) && (tag == bus.tag);
    endfunction

    always_comb begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            busy_vec[i] = ent[i].busy;
            ready_vec[i] = ent[i].busy &&
                           (ent[i].tag_x == rs_pkg::TAG_UNLOCKED) &&
                           (ent[i].tag_y == rs_pkg::TAG_UNLOCKED);
        end
    end

    // scan downward so the lowest index wins.
    always_comb begin
        free_idx = 1'b0;
        issue_idx = 1'b0;
        for (int i = rs_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                free_idx = 1'(i);
            end
            if (ready_vec[i]) begin
                issue_idx = 1'(i);
            end
        end
    end

    assign rs_full = &busy_vec;
    assign issue_valid = |ready_vec;
    assign issue_entry = ent[issue_idx];
    assign accept = dispatch_en && !rs_full; // a strobe while full is dropped.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
                ent[i].busy <= 1'b0;
                ent[i].tag_x <= rs_pkg::TAG_UNLOCKED;
                ent[i].tag_y <= rs_pkg::TAG_UNLOCKED;
                ent[i].tag_w <= rs_pkg::TAG_UNLOCKED;
            end
        end else begin
            for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
                if (accept && (free_idx == 1'(i))) begin
                    ent[i].busy <= 1'b1;
                    ent[i].op <= dispatch.op;
                    ent[i].tag_w <= dispatch.tag_w;

                    // a producer broadcasting right now is taken directly.
                    if (cdb_hit(dispatch.tag_x, cdb)) begin
                        ent[i].tag_x <= rs_pkg::TAG_UNLOCKED;
                        ent[i].data_x <= cdb.data;
                    end else begin
                        ent[i].tag_x <= dispatch.tag_x;
                        ent[i].data_x <= dispatch.data_x;
                    end

                    if (cdb_hit(dispatch.tag_y, cdb)) begin
                        ent[i].tag_y <= rs_pkg::TAG_UNLOCKED;
                        ent[i].data_y <= cdb.data;
                    end else begin
                        ent[i].tag_y <= dispatch.tag_y;
                        ent[i].data_y <= dispatch.data_y;
                    end
                end else begin
                    if (issue_take && (issue_idx == 1'(i))) begin
                        ent[i].busy <= 1'b0; // entry now lives in the ALU.
                    end

                    if (ent[i].busy && cdb_hit(ent[i].tag_x, cdb)) begin
                        ent[i].tag_x <= rs_pkg::TAG_UNLOCKED;
                        ent[i].data_x <= cdb.data;
                    end

                    if (ent[i].busy && cdb_hit(ent[i].tag_y, cdb)) begin
                        ent[i].tag_y <= rs_pkg::TAG_UNLOCKED;
                        ent[i].data_y <= cdb.data;
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      exec_load,
    input  rs_pkg::rs_entry_t         issue_entry,
    output logic [rs_pkg::WORD_W-1:0] alu_result
);

    rs_pkg::alu_op_t           op_q;
    logic [rs_pkg::WORD_W-1:0] x_q;
    logic [rs_pkg::WORD_W-1:0] y_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= rs_pkg::op_add;
        end else if (exec_load) begin
            op_q <= issue_entry.op;
        end
    end

    // operands hold still for the whole multiply wait.
    always_ff @(posedge clk) begin
        if (exec_load) begin
            x_q <= issue_entry.data_x;
            y_q <= issue_entry.data_y;
        end
    end

    always_comb begin
        case (op_q)
            rs_pkg::op_add: alu_result = x_q + y_q;
            rs_pkg::op_sub: alu_result = x_q - y_q;
            rs_pkg::op_and: alu_result = x_q & y_q;
            rs_pkg::op_or:  alu_result = x_q | y_q;
            rs_pkg::op_xor: alu_result = x_q ^ y_q;
            rs_pkg::op_sll: alu_result = x_q << y_q[4:0];
            rs_pkg::op_srl: alu_result = x_q >> y_q[4:0];
            rs_pkg::op_mul: alu_result = x_q * y_q; // low word of the product.
            default:        alu_result = '0;
        endcase
    end

endmodule

// ==== hdl/exec_timer.sv ====
`timescale 1ns/1ns

module exec_timer (
    input  logic clk,
    input  logic rst,
    input  logic timer_start,
    output logic timer_done
);

    logic [rs_pkg::TIMER_W-1:0] count;
    logic                       active;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            count <= '0;
        end else if (timer_start) begin
            active <= 1'b1;
            count <= rs_pkg::MUL_LOAD; // done lands MUL_CYCLES after start.
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign timer_done = active && (count == '0);

endmodule

// ==== hdl/rs_pkg.sv ====
package rs_pkg;

    localparam int WORD_W = 32;
    localparam int TAG_W = 4;
    localparam int RS_DEPTH = 2;

    localparam logic [TAG_W-1:0] TAG_UNLOCKED = '0; // operand value is present.

    // multiply latency from issue to result ready.
    localparam int MUL_CYCLES = 4;
    localparam int TIMER_W = $clog2(MUL_CYCLES);
    localparam logic [TIMER_W-1:0] MUL_LOAD = TIMER_W'(MUL_CYCLES - 1);

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll, // shift amount is y[4:0].
        op_srl,
        op_mul
    } alu_op_t;

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_bcast
    } issue_state_t;

    typedef struct packed {
        alu_op_t           op;
        logic [TAG_W-1:0]  tag_x;
        logic [TAG_W-1:0]  tag_y;
        logic [TAG_W-1:0]  tag_w;
        logic [WORD_W-1:0] data_x;
        logic [WORD_W-1:0] data_y;
    } dispatch_t;

    typedef struct packed {
        logic              busy;
        alu_op_t           op;
        logic [TAG_W-1:0]  tag_x;
        logic [TAG_W-1:0]  tag_y;
        logic [TAG_W-1:0]  tag_w;
        logic [WORD_W-1:0] data_x;
        logic [WORD_W-1:0] data_y;
    } rs_entry_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [WORD_W-1:0] data;
    } cdb_t;

endpackage
